//--- files.f
hdl/view_pkg.sv
hdl/object_table.sv
hdl/sprite_drawer.sv
hdl/frame_sequencer.sv
hdl/pixel_merge.sv
hdl/game_view.sv
testbench/game_view_props.sv
testbench/tb_game_view.sv

//--- run.sh
#!/bin/sh
# build and run the game_view testbench with Verilator
# exit status is nonzero unless the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_game_view -f files.f &&
./obj_dir/Vtb_game_view | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tb_game_view.sv
// testbench for game_view with 4 slots of 4x4 squares
// each table entry loads the slots, probes one address and checks one frame
`timescale 1ns/100ps

module tb_game_view;
	import view_pkg::*;

	localparam int NUM_OBJECTS  = 4;
	localparam int SPRITE_SIZE  = 4;
	localparam int N_TESTS      = 5;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 8;
	localparam int DRIVE_DLY    = 1;
	// frame plus register traffic per test, doubled
	localparam int CYCLE_LIMIT  = RESET_CYCLES +
		N_TESTS * (NUM_OBJECTS * (SPRITE_SIZE * SPRITE_SIZE + 3) + 40) * 2;

	logic      clk;
	logic      reset;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_word_t pwdata;
	apb_word_t prdata;
	logic      pready;
	logic      pslverr;
	pixel_t    pixel;
	logic      write_en;
	logic      frame_done;

	// stimulus table, one frame per entry
	string     test_name [N_TESTS];
	object_t   test_obj  [N_TESTS][NUM_OBJECTS];
	apb_addr_t probe_addr[N_TESTS];
	logic      probe_err [N_TESTS];

	pixel_t got_q[$];
	pixel_t exp_q[$];
	string  cur_test;
	integer seed;
	int     frames_seen;
	int     error_count;
	int     cycles;
	logic   done_prev;

	game_view #(.NUM_OBJECTS(NUM_OBJECTS), .SPRITE_SIZE(SPRITE_SIZE)) i_game_view (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pixel(pixel),
		.write_en(write_en),
		.frame_done(frame_done)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles in %s", cycles, cur_test);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// write port monitor, sampled at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (write_en) begin
				got_q.push_back(pixel);
			end
			if (frame_done) begin
				frames_seen = frames_seen + 1;
				if (done_prev) begin
					error_count = error_count + 1;
					$display("frame_done stayed high for two cycles in %s", cur_test);
				end
			end
		end
		done_prev = frame_done;
	end

	// register map as the host sees it
	function automatic logic is_mapped(input apb_addr_t addr);
		int slot;
		int off;
		slot = int'(addr) / 8;
		off  = int'(addr) % 8;
		return (addr == CTRL_ADDR) || ((slot < NUM_OBJECTS) && (off == 0 || off == 4));
	endfunction

	function automatic apb_addr_t slot_addr(input int i, input apb_addr_t off);
		return apb_addr_t'(i * 8) + off;
	endfunction

	// x 31:23, y 18:11, visible bit 1
	function automatic apb_word_t pos_word(input object_t o);
		return {o.x, 4'b0, o.y, 9'b0, o.visible, 1'b0};
	endfunction

	function automatic apb_word_t color_word(input object_t o);
		return {20'b0, o.color};
	endfunction

	task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			error_count = error_count + 1;
			$display("Mismatch %s %s: expected x=%0d y=%0d color=%h actual x=%0d y=%0d color=%h",
				cur_test, what, exp.x, exp.y, exp.color, act.x, act.y, act.color);
		end
	endtask

	task automatic check_word(input string what, input apb_word_t exp, input apb_word_t act);
		if (act !== exp) begin
			error_count = error_count + 1;
			$display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			error_count = error_count + 1;
			$display("Mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			error_count = error_count + 1;
			$display("Mismatch %s %s: expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	// setup phase then one access phase, no wait states
	task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#DRIVE_DLY;
		penable = 1'b1;
		@(negedge clk);
		check_bit("pready on write", 1'b1, pready);
		check_bit($sformatf("pslverr on write %h", addr), !is_mapped(addr), pslverr);
		@(posedge clk);
		#DRIVE_DLY;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_word_t data, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#DRIVE_DLY;
		penable = 1'b1;
		// prdata is combinational in the access phase
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_bit("pready on read", 1'b1, pready);
		check_bit($sformatf("pslverr on read %h", addr), !is_mapped(addr), err);
		@(posedge clk);
		#DRIVE_DLY;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic load_tests();
		logic [31:0] rnd;
		for (int t = 0; t < N_TESTS; t++) begin
			for (int i = 0; i < NUM_OBJECTS; i++) begin
				rnd = $random(seed);
				test_obj[t][i].x       = rnd[8:0];
				test_obj[t][i].y       = rnd[16:9];
				test_obj[t][i].color   = rnd[28:17] | 12'h001;
				test_obj[t][i].visible = 1'b1;
			end
		end
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			// odd slots visible only
			test_obj[1][i].visible = (i % 2 == 1);
			if (i % 2 == 0) begin
				test_obj[2][i].color = '0;
			end
			test_obj[4][i].visible = (i % 3 != 1);
			if (i % 3 == 2) begin
				test_obj[4][i].color = '0;
			end
		end
		// corner near the bottom right, square wraps in both axes
		test_obj[3][0].x = 9'd510;
		test_obj[3][0].y = 8'd254;
		test_name[0] = "full_frame";
		test_name[1] = "invisible_slots";
		test_name[2] = "transparent_slots";
		test_name[3] = "coordinate_wrap";
		test_name[4] = "mixed_slots";
		probe_addr[0] = 8'h0c;
		probe_err[0]  = 1'b0;
		probe_addr[1] = 8'h02;
		probe_err[1]  = 1'b1;
		probe_addr[2] = 8'h84;
		probe_err[2]  = 1'b1;
		probe_addr[3] = apb_addr_t'(NUM_OBJECTS * 8);
		probe_err[3]  = 1'b1;
		probe_addr[4] = CTRL_ADDR;
		probe_err[4]  = 1'b0;
	endtask

	// row-major model, column inner, coordinates wrap
	task automatic build_expected(input int t);
		object_t o;
		pixel_t  p;
		exp_q.delete();
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			o = test_obj[t][i];
			if (o.visible && o.color != 12'h000) begin
				for (int r = 0; r < SPRITE_SIZE; r++) begin
					for (int c = 0; c < SPRITE_SIZE; c++) begin
						p.x     = coord_x_t'((int'(o.x) + c) % 512);
						p.y     = coord_y_t'((int'(o.y) + r) % 256);
						p.color = o.color;
						exp_q.push_back(p);
					end
				end
			end
		end
	endtask

	task automatic run_test(input int t);
		object_t   ones;
		apb_word_t junk;
		apb_word_t wval;
		apb_word_t rdata;
		logic      err;
		int        frames_before;
		cur_test = test_name[t];
		ones = '1;
		// slot words with noise in the unused bits
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			junk = $random(seed);
			wval = pos_word(test_obj[t][i]) | (junk & ~pos_word(ones));
			apb_write(slot_addr(i, OBJ_POS_OFFSET), wval);
			junk = $random(seed);
			wval = color_word(test_obj[t][i]) | (junk & ~32'hfff);
			apb_write(slot_addr(i, OBJ_COLOR_OFFSET), wval);
		end
		apb_read(probe_addr[t], rdata, err);
		check_bit("probe pslverr", probe_err[t], err);
		if (probe_err[t]) begin
			apb_write(probe_addr[t], '1);
		end
		// readback also shows the unmapped write changed nothing
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			apb_read(slot_addr(i, OBJ_POS_OFFSET), rdata, err);
			check_word($sformatf("slot %0d position", i), pos_word(test_obj[t][i]), rdata);
			apb_read(slot_addr(i, OBJ_COLOR_OFFSET), rdata, err);
			check_word($sformatf("slot %0d colour", i), color_word(test_obj[t][i]), rdata);
		end
		got_q.delete();
		frames_before = frames_seen;
		apb_write(CTRL_ADDR, 32'h1);
		apb_read(CTRL_ADDR, rdata, err);
		check_bit("busy during frame", 1'b1, rdata[0]);
		// second start lands while busy and must be dropped
		apb_write(CTRL_ADDR, 32'h1);
		while (frames_seen == frames_before) begin
			@(posedge clk);
		end
		// nothing may follow the frame end
		repeat (IDLE_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		apb_read(CTRL_ADDR, rdata, err);
		check_word("control word after frame", 32'h0, rdata);
		check_count("frame count", frames_before + 1, frames_seen);
		build_expected(t);
		if (t == 0) begin
			check_count("full frame size", NUM_OBJECTS * SPRITE_SIZE * SPRITE_SIZE, got_q.size());
		end
		check_count("pixel count", exp_q.size(), got_q.size());
		for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
			check_pixel($sformatf("pixel %0d", k), exp_q[k], got_q[k]);
		end
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		seed        = 96;
		cycles      = 0;
		frames_seen = 0;
		error_count = 0;
		done_prev   = 1'b0;
		cur_test    = "reset";
		load_tests();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		for (int t = 0; t < N_TESTS; t++) begin
			run_test(t);
		end
		$display("tests run %0d, frames %0d, errors %0d", N_TESTS, frames_seen, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/game_view_props.sv
// concurrent checks on the APB and pixel ports of game_view
// attached to every game_view instance through bind
`timescale 1ns/100ps

module game_view_props (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic write_en,
	input logic frame_done
);

	// zero wait states, so pready is high in every access phase
	a_pready_access: assert property (
		@(posedge clk) disable iff (reset) (psel && penable) |-> pready
	) else $error("pready low in an APB access phase");

	// quiet outputs once reset has been held for a full cycle
	a_quiet_in_reset: assert property (
		@(posedge clk) (reset && $past(reset)) |-> (!write_en && !frame_done)
	) else $error("write_en or frame_done high while reset is asserted");

	// frame end is a single cycle pulse
	a_done_pulse: assert property (
		@(posedge clk) disable iff (reset) frame_done |=> !frame_done
	) else $error("frame_done high in two consecutive cycles");

endmodule

bind game_view game_view_props i_game_view_props (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.write_en(write_en),
	.frame_done(frame_done)
);

//--- hdl/game_view.sv
// frame drawing view, APB object table in front of a row of square drawers
// the frame buffer is assumed always ready and cleared elsewhere
`timescale 1ns/100ps

module game_view
	import view_pkg::*;
#(
	parameter int NUM_OBJECTS = 4,
	parameter int SPRITE_SIZE = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_word_t pwdata,
	output apb_word_t prdata,
	output logic      pready,
	output logic      pslverr,
	output pixel_t    pixel,
	output logic      write_en,
	output logic      frame_done
);

	localparam int SLOT_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1;

	object_t [NUM_OBJECTS-1:0] objects;
	pixel_t [NUM_OBJECTS-1:0]  pix;
	logic [NUM_OBJECTS-1:0]    pix_valid;
	logic [NUM_OBJECTS-1:0]    draw_start;
	logic [NUM_OBJECTS-1:0]    draw_done;
	logic [SLOT_W-1:0]         active_slot;
	logic                      frame_start;
	logic                      busy;

	object_table #(.NUM_OBJECTS(NUM_OBJECTS), .SLOT_W(SLOT_W)) i_object_table (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.busy(busy),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.objects(objects),
		.frame_start(frame_start)
	);

	frame_sequencer #(.NUM_OBJECTS(NUM_OBJECTS), .SLOT_W(SLOT_W)) i_frame_sequencer (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.draw_done(draw_done),
		.draw_start(draw_start),
		.active_slot(active_slot),
		.busy(busy),
		.frame_done(frame_done)
	);

	// one drawer per object slot
	for (genvar i = 0; i < NUM_OBJECTS; i++) begin : g_drawer
		sprite_drawer #(.SPRITE_SIZE(SPRITE_SIZE)) i_sprite_drawer (
			.clk(clk),
			.reset(reset),
			.draw_start(draw_start[i]),
			.obj(objects[i]),
			.pix(pix[i]),
			.pix_valid(pix_valid[i]),
			.draw_done(draw_done[i])
		);
	end

	pixel_merge #(.NUM_OBJECTS(NUM_OBJECTS), .SLOT_W(SLOT_W)) i_pixel_merge (
		.clk(clk),
		.reset(reset),
		.pix(pix),
		.pix_valid(pix_valid),
		.active_slot(active_slot),
		.pixel(pixel),
		.write_en(write_en)
	);

endmodule

//--- hdl/pixel_merge.sv
// picks the active drawer's pixel and registers the write port
// one register stage, transparent pixels are not written
`timescale 1ns/100ps

module pixel_merge
	import view_pkg::*;
#(
	parameter int NUM_OBJECTS = 4,
	parameter int SLOT_W      = 2
) (
	input  logic                        clk,
	input  logic                        reset,
	input  pixel_t [NUM_OBJECTS-1:0]    pix,
	input  logic [NUM_OBJECTS-1:0]      pix_valid,
	input  logic [SLOT_W-1:0]           active_slot,
	output pixel_t                      pixel,
	output logic                        write_en
);

	pixel_t sel_pix;
	logic   sel_valid;

	// only the active drawer is ever running
	assign sel_pix   = pix[active_slot];
	assign sel_valid = pix_valid[active_slot];

	always_ff @(posedge clk) begin
		if (reset) begin
			write_en <= 1'b0;
		end else begin
			// colour zero is transparent
			write_en <= sel_valid && (sel_pix.color != '0);
		end
	end

	// payload follows without reset
	always_ff @(posedge clk) begin
		pixel <= sel_pix;
	end

endmodule

//--- hdl/frame_sequencer.sv
// starts the drawers one at a time in slot order and marks the frame end
// frame_start is ignored while a frame is running
`timescale 1ns/100ps

module frame_sequencer
	import view_pkg::*;
#(
	parameter int NUM_OBJECTS = 4,
	parameter int SLOT_W      = 2
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   frame_start,
	input  logic [NUM_OBJECTS-1:0] draw_done,
	output logic [NUM_OBJECTS-1:0] draw_start,
	output logic [SLOT_W-1:0]      active_slot,
	output logic                   busy,
	output logic                   frame_done
);

	seq_state_t        state;
	logic [SLOT_W-1:0] slot;
	logic              last_slot;

	assign last_slot = (slot == SLOT_W'(NUM_OBJECTS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			slot  <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (frame_start) begin
						state <= SEQ_START;
						slot  <= '0;
					end
				end
				// draw_start is high for exactly this one cycle
				SEQ_START: begin
					state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin
					// next slot starts the cycle after draw_done
					if (draw_done[slot]) begin
						if (last_slot) begin
							state <= SEQ_DONE;
						end else begin
							state <= SEQ_START;
							slot  <= slot + 1'b1;
						end
					end
				end
				SEQ_DONE: begin
					// frame end lasts one cycle, a new start is taken in idle
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// one-hot start for the current slot
	assign draw_start = (state == SEQ_START) ? (NUM_OBJECTS'(1) << slot) : '0;

	assign active_slot = slot;
	// busy drops on the same edge that raises frame_done
	assign busy       = (state == SEQ_START) || (state == SEQ_WAIT);
	assign frame_done = (state == SEQ_DONE);

endmodule

//--- hdl/sprite_drawer.sv
// draws one square object in row-major order, one pixel per cycle
// the object is captured at draw_start, coordinates wrap, no clipping
`timescale 1ns/100ps

module sprite_drawer
	import view_pkg::*;
#(
	parameter int SPRITE_SIZE = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    draw_start,
	input  object_t obj,
	output pixel_t  pix,
	output logic    pix_valid,
	output logic    draw_done
);

	localparam int CNT_W = (SPRITE_SIZE > 1) ? $clog2(SPRITE_SIZE) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(SPRITE_SIZE - 1);

	pixel_t           base;
	logic [CNT_W-1:0] col;
	logic [CNT_W-1:0] row;
	logic             running;
	logic             skip_done;
	logic             at_end;

	// last pixel of the square
	assign at_end = (col == LAST) && (row == LAST);

	// corner and colour of the square being drawn
	always_ff @(posedge clk) begin
		if (draw_start) begin
			base <= '{x: obj.x, y: obj.y, color: obj.color};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running   <= 1'b0;
			skip_done <= 1'b0;
			col       <= '0;
			row       <= '0;
		end else if (draw_start) begin
			// an invisible object only signals done on the next cycle
			running   <= obj.visible;
			skip_done <= !obj.visible;
			col       <= '0;
			row       <= '0;
		end else begin
			skip_done <= 1'b0;
			if (running) begin
				// column is the inner count
				if (col == LAST) begin
					col <= '0;
					row <= row + 1'b1;
					if (row == LAST) begin
						running <= 1'b0;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// offset from the corner, truncation does the wrap
	always_comb begin
		pix.x     = base.x + coord_x_t'(col);
		pix.y     = base.y + coord_y_t'(row);
		pix.color = base.color;
	end

	assign pix_valid = running;
	// done comes with the last pixel
	assign draw_done = (running && at_end) || skip_done;

endmodule

//--- hdl/object_table.sv
// APB slave with the object slots and the control register, no wait states
// unmapped addresses raise pslverr and are not written
// a start write while busy is dropped
`timescale 1ns/100ps

module object_table
	import view_pkg::*;
#(
	parameter int NUM_OBJECTS = 4,
	parameter int SLOT_W      = 2
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  apb_addr_t                   paddr,
	input  apb_word_t                   pwdata,
	input  logic                        busy,
	output apb_word_t                   prdata,
	output logic                        pready,
	output logic                        pslverr,
	output object_t [NUM_OBJECTS-1:0]   objects,
	output logic                        frame_start
);

	logic        access;
	logic        wr;
	apb_addr_t   slot_idx;
	apb_addr_t   slot_off;
	logic        slot_hit;
	logic        pos_hit;
	logic        color_hit;
	logic        ctrl_hit;
	logic [SLOT_W-1:0] sel;

	// access phase of an APB transfer
	assign access = psel && penable;
	assign wr     = access && pwrite;

	// split the byte address into slot number and offset in the slot
	assign slot_idx = paddr / SLOT_STRIDE;
	assign slot_off = paddr % SLOT_STRIDE;
	assign sel      = slot_idx[SLOT_W-1:0];

	assign slot_hit  = slot_idx < apb_addr_t'(NUM_OBJECTS);
	assign pos_hit   = slot_hit && (slot_off == OBJ_POS_OFFSET);
	assign color_hit = slot_hit && (slot_off == OBJ_COLOR_OFFSET);
	assign ctrl_hit  = (paddr == CTRL_ADDR);

	// zero wait states
	assign pready  = 1'b1;
	assign pslverr = access && !(pos_hit || color_hit || ctrl_hit);

	// read mux, unused bits read as zero
	always_comb begin
		prdata = '0;
		if (pos_hit) begin
			prdata[POS_X_LSB +: $bits(coord_x_t)] = objects[sel].x;
			prdata[POS_Y_LSB +: $bits(coord_y_t)] = objects[sel].y;
			prdata[POS_VIS_BIT]                   = objects[sel].visible;
		end else if (color_hit) begin
			prdata[COLOR_LSB +: $bits(color_t)] = objects[sel].color;
		end else if (ctrl_hit) begin
			prdata[CTRL_BUSY_BIT] = busy;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// every slot comes up invisible
			objects     <= '0;
			frame_start <= 1'b0;
		end else begin
			// frame_start is also checked so a pulse never repeats
			// before busy has risen
			frame_start <= wr && ctrl_hit && pwdata[CTRL_START_BIT] &&
				!busy && !frame_start;
			// slot writes go through while busy, the drawer already
			// holds its own copy
			if (wr && pos_hit) begin
				objects[sel].x       <= pwdata[POS_X_LSB +: $bits(coord_x_t)];
				objects[sel].y       <= pwdata[POS_Y_LSB +: $bits(coord_y_t)];
				objects[sel].visible <= pwdata[POS_VIS_BIT];
			end
			if (wr && color_hit) begin
				objects[sel].color <= pwdata[COLOR_LSB +: $bits(color_t)];
			end
		end
	end

endmodule

//--- hdl/view_pkg.sv
// shared types and APB register map for the frame drawing view
// coordinates wrap modulo their width, colour zero is transparent
package view_pkg;

	// screen and data widths
	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	typedef logic [11:0] color_t;
	typedef logic [31:0] apb_word_t;
	typedef logic [7:0]  apb_addr_t;

	// one object slot as held by the table, 30 bits
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
		logic     visible;
	} object_t;

	// one pixel towards the frame buffer, 29 bits
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pixel_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_START,
		SEQ_WAIT,
		SEQ_DONE
	} seq_state_t;

	// register map, each slot takes 8 bytes
	localparam apb_addr_t SLOT_STRIDE      = 8'd8;
	localparam apb_addr_t OBJ_POS_OFFSET   = 8'd0;
	localparam apb_addr_t OBJ_COLOR_OFFSET = 8'd4;
	localparam apb_addr_t CTRL_ADDR        = 8'h80;

	// field positions inside the data words
	localparam int POS_X_LSB      = 23;
	localparam int POS_Y_LSB      = 11;
	localparam int POS_VIS_BIT    = 1;
	localparam int COLOR_LSB      = 0;
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_BUSY_BIT  = 0;

endpackage
